/* board_monitor.f */
+incdir+verification
hdl/board_monitor_pkg.sv
hdl/freq_meter.sv
hdl/monitor_regs.sv
hdl/led_driver.sv
hdl/board_monitor.sv
verification/board_monitor_tb.sv

/* verification/axil_master_tasks.svh */
`ifndef AXIL_MASTER_TASKS_SVH
`define AXIL_MASTER_TASKS_SVH

// A stall holds bready low while a read probe at 0x40 must stay unaccepted.
task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input int stall, output logic [1:0] resp);
	int waited;
	@(negedge hw);
	axil_req.awvalid = 1'b1; // Address and data together.
	axil_req.awaddr = addr;
	axil_req.wvalid = 1'b1;
	axil_req.wdata = data;
	axil_req.wstrb = strb;
	waited = 0;
	do begin
		@(posedge hw);
		waited++;
		if (waited > BUS_TIMEOUT) give_up("write address and data were never accepted");
	end while (!(axil_rsp.awready && axil_rsp.wready));
	@(negedge hw);
	axil_req.awvalid = 1'b0;
	axil_req.wvalid = 1'b0;
	axil_req.araddr = 8'h40;
	axil_req.arvalid = (stall > 0); // Probe during back-pressure.
	repeat (stall) @(negedge hw);
	axil_req.arvalid = 1'b0;
	axil_req.bready = 1'b1;
	waited = 0;
	do begin
		@(posedge hw);
		waited++;
		if (waited > BUS_TIMEOUT) give_up("write response never arrived");
	end while (!axil_rsp.bvalid);
	resp = axil_rsp.bresp; // Taken at the response handshake.
	@(negedge hw);
	axil_req.bready = 1'b0;
endtask

// A stall holds rready low while a write probe at 0x40 must stay unaccepted.
task automatic read_reg(input logic [7:0] addr, input int stall,
		output logic [31:0] data, output logic [1:0] resp);
	int waited;
	@(negedge hw);
	axil_req.arvalid = 1'b1;
	axil_req.araddr = addr;
	waited = 0;
	do begin
		@(posedge hw);
		waited++;
		if (waited > BUS_TIMEOUT) give_up("read address was never accepted");
	end while (!axil_rsp.arready);
	@(negedge hw);
	axil_req.arvalid = 1'b0;
	axil_req.awaddr = 8'h40;
	axil_req.wdata = '0;
	axil_req.wstrb = '0;
	axil_req.awvalid = (stall > 0); // Probe during back-pressure.
	axil_req.wvalid = (stall > 0);
	repeat (stall) @(negedge hw);
	axil_req.awvalid = 1'b0;
	axil_req.wvalid = 1'b0;
	axil_req.rready = 1'b1;
	waited = 0;
	do begin
		@(posedge hw);
		waited++;
		if (waited > BUS_TIMEOUT) give_up("read data never arrived");
	end while (!axil_rsp.rvalid);
	data = axil_rsp.rdata;
	resp = axil_rsp.rresp;
	@(negedge hw);
	axil_req.rready = 1'b0;
endtask

`endif

/* verification/board_monitor_tb.sv */
`timescale 1ns/1ps

module board_monitor_tb;
	import board_monitor_pkg::*;

	localparam int HW_PERIOD_NS = 10;
	localparam int BUS_TIMEOUT = 64; // Cycles allowed per bus wait.
	localparam int SEED = 55567;
	localparam int PERIOD_NS [NUM_METERS] = '{40, 60, 80, 100}; // Board clock periods.

	logic hw;
	logic rst_n;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	logic [NUM_METERS-1:0] meter_clks;
	logic [7:0] leds;
	logic prev_bstall = 1'b0; // Write response held last cycle.
	logic prev_rstall = 1'b0;
	logic [1:0] prev_bresp;
	logic [1:0] prev_rresp;
	logic [31:0] prev_rdata;

	board_monitor UUT (
		.hw(hw),
		.rst_n(rst_n),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.meter_clks(meter_clks),
		.leds(leds)
	);

	task automatic fail_run();
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped at the first failure.");
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		$display("Error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
		fail_run();
	endtask

	task automatic give_up(input string why);
		$display("Timeout: %s.", why);
		fail_run();
	endtask

	task automatic expect_equal(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else report_mismatch(what, got, exp);
	endtask

	`include "axil_master_tasks.svh"

	function automatic logic [31:0] ctrl_word(input logic en, input led_mode_e mode);
		logic [31:0] word;
		word = '0;
		word[CTRL_EN_BIT] = en;
		word[CTRL_MODE_LSB +: 2] = mode;
		return word;
	endfunction

	// Expected count is 10240 / P, one count either way.
	task automatic check_freqs(input logic running);
		logic [31:0] data;
		logic [1:0] resp;
		int expected;
		int tol;
		for (int i = 0; i < NUM_METERS; i++) begin
			read_reg(8'(REG_FREQ0) + 8'(4 * i), 0, data, resp);
			expected = running ? (GATE_CYCLES * HW_PERIOD_NS) / PERIOD_NS[i] : 0;
			tol = running ? 1 : 0; // Stopped meters read exactly zero.
			assert (resp == RESP_OKAY && int'(data) >= expected - tol
					&& int'(data) <= expected + tol)
				else report_mismatch($sformatf("REG_FREQ%0d", i), data, 32'(expected));
		end
	endtask

	initial begin
		hw = 1'b0;
		forever #(HW_PERIOD_NS / 2) hw = ~hw;
	end

	initial begin
		meter_clks = '0; // All edges land on hw falling edges.
		fork
			forever #(PERIOD_NS[0] / 2) meter_clks[0] = ~meter_clks[0];
			forever #(PERIOD_NS[1] / 2) meter_clks[1] = ~meter_clks[1];
			forever #(PERIOD_NS[2] / 2) meter_clks[2] = ~meter_clks[2];
			forever #(PERIOD_NS[3] / 2) meter_clks[3] = ~meter_clks[3];
		join
	end

	// Held responses must not move until the master takes them.
	always @(posedge hw) begin
		if (rst_n && prev_bstall) begin
			assert (axil_rsp.bvalid && axil_rsp.bresp == prev_bresp)
				else report_mismatch("write response moved under stall",
					{axil_rsp.bvalid, axil_rsp.bresp}, {1'b1, prev_bresp});
		end
		if (rst_n && prev_rstall) begin
			assert (axil_rsp.rvalid && axil_rsp.rresp == prev_rresp)
				else report_mismatch("read response moved under stall",
					{axil_rsp.rvalid, axil_rsp.rresp}, {1'b1, prev_rresp});
			assert (axil_rsp.rdata === prev_rdata)
				else report_mismatch("rdata moved under stall", axil_rsp.rdata, prev_rdata);
		end
		prev_bstall = rst_n && axil_rsp.bvalid && !axil_req.bready;
		prev_rstall = rst_n && axil_rsp.rvalid && !axil_req.rready;
		prev_bresp = axil_rsp.bresp;
		prev_rresp = axil_rsp.rresp;
		prev_rdata = axil_rsp.rdata;
	end

	assert property (@(posedge hw) disable iff (!rst_n) axil_rsp.awready == axil_rsp.wready)
		else report_mismatch("awready and wready out of step",
			32'(axil_rsp.awready), 32'(axil_rsp.wready));

	assert property (@(posedge hw) disable iff (!rst_n)
			(axil_rsp.bvalid || axil_rsp.rvalid) |-> !(axil_rsp.awready || axil_rsp.arready))
		else report_mismatch("address accepted with a response pending",
			{axil_rsp.awready, axil_rsp.arready}, 32'h0);

	initial begin
		logic [31:0] data;
		logic [1:0] resp;
		logic [7:0] pat;
		logic [7:0] first;
		logic [3:0] toggled;
		int waited;
		void'($urandom(SEED)); // Seeds the generator once.
		axil_req = '0;
		rst_n = 1'b0;
		repeat (5) @(negedge hw);
		rst_n = 1'b1;
		expect_equal("bus outputs after reset", {axil_rsp.awready, axil_rsp.wready,
			axil_rsp.arready, axil_rsp.bvalid, axil_rsp.rvalid}, 32'h0);
		expect_equal("leds after reset", leds, 32'h0);
		read_reg(REG_ID, 0, data, resp);
		expect_equal("REG_ID", data, BOARD_ID);
		expect_equal("REG_ID response", resp, RESP_OKAY);
		read_reg(REG_CTRL, 0, data, resp);
		expect_equal("REG_CTRL reset value", data, ctrl_word(1'b1, LED_HEARTBEAT));

		repeat (3 * GATE_CYCLES) @(negedge hw); // Three gate windows.
		check_freqs(1'b1);

		pat = 8'($urandom);
		write_reg(REG_PATTERN, {24'h0, pat}, 4'hF, 0, resp);
		read_reg(REG_PATTERN, 0, data, resp);
		expect_equal("REG_PATTERN readback", data, {24'h0, pat});
		write_reg(REG_CTRL, ctrl_word(1'b1, LED_PATTERN), 4'h3, 0, resp);
		repeat (2) @(negedge hw);
		repeat (8) begin
			expect_equal("leds in pattern mode", leds, pat);
			@(negedge hw);
		end
		write_reg(REG_PATTERN, {24'h0, ~pat}, 4'b1110, 0, resp); // Byte 0 masked.
		read_reg(REG_PATTERN, 0, data, resp);
		expect_equal("REG_PATTERN after masked write", data, {24'h0, pat});
		write_reg(REG_CTRL, ctrl_word(1'b1, LED_OFF), 4'h3, 0, resp);
		repeat (2) @(negedge hw);
		expect_equal("leds in off mode", leds, 32'h0);

		write_reg(REG_CTRL, ctrl_word(1'b1, LED_HEARTBEAT), 4'h3, 0, resp);
		repeat (2) @(negedge hw);
		first = leds;
		waited = 0;
		do begin
			@(negedge hw);
			waited++;
			if (waited > (1 << HB_SHIFT) + 2) give_up("heartbeat LEDs never changed");
		end while (leds == first);
		write_reg(REG_CTRL, ctrl_word(1'b1, LED_ACTIVITY), 4'h3, 0, resp);
		repeat (2) @(negedge hw);
		first = leds;
		toggled = '0;
		waited = 0;
		do begin
			@(negedge hw);
			waited++;
			expect_equal("upper leds in activity mode", leds[7:4], 32'h0);
			toggled = toggled | (leds[3:0] ^ first[3:0]); // Sticky per meter.
			if (waited > 2 * GATE_CYCLES) give_up("activity LEDs did not all toggle");
		end while (toggled != 4'hF);

		write_reg(REG_CTRL, ctrl_word(1'b0, LED_ACTIVITY), 4'h1, 0, resp);
		check_freqs(1'b0);
		write_reg(REG_CTRL, ctrl_word(1'b1, LED_ACTIVITY), 4'h1, 0, resp);
		repeat (2 * GATE_CYCLES + 4) @(negedge hw); // Two windows plus sync delay.
		check_freqs(1'b1);

		write_reg(REG_FREQ0, 32'hDEAD_BEEF, 4'hF, 0, resp);
		expect_equal("read-only write response", resp, RESP_OKAY);
		check_freqs(1'b1);
		write_reg(8'h40, 32'h1234_5678, 4'hF, 0, resp);
		expect_equal("unmapped write response", resp, RESP_SLVERR);
		read_reg(8'h40, 0, data, resp);
		expect_equal("unmapped read response", resp, RESP_SLVERR);
		expect_equal("unmapped read data", data, 32'h0);
		pat = 8'($urandom);
		write_reg(REG_PATTERN, {24'h0, pat}, 4'hF, 1 + ($urandom % 8), resp);
		expect_equal("stalled write response", resp, RESP_OKAY);
		read_reg(REG_PATTERN, 1 + ($urandom % 8), data, resp);
		expect_equal("stalled pattern read", data, {24'h0, pat});
		read_reg(REG_ID, 1 + ($urandom % 8), data, resp);
		expect_equal("stalled REG_ID read", data, BOARD_ID);

		$display("=== PASS ===");
		$finish;
	end

endmodule

/* hdl/board_monitor.sv */
`timescale 1ns/1ps

module board_monitor (
	input logic hw,
	input logic rst_n,
	input board_monitor_pkg::axil_req_t axil_req,
	output board_monitor_pkg::axil_rsp_t axil_rsp,
	input logic [board_monitor_pkg::NUM_METERS-1:0] meter_clks,
	output logic [7:0] leds
);
	import board_monitor_pkg::*;

	monitor_ctrl_t ctrl; // Register outputs to the datapath.
	freq_result_t results [NUM_METERS]; // Meter results back to registers.
	logic [NUM_METERS-1:0] meter_valid; // Update pulses for the LEDs.

	monitor_regs u_regs (
		.hw(hw),
		.rst_n(rst_n),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.results(results),
		.ctrl(ctrl)
	);

	// One meter per board clock, all timed from hw.
	generate
		for (genvar i = 0; i < NUM_METERS; i++) begin : gen_meter
			freq_meter u_meter (
				.hw(hw),
				.rst_n(rst_n),
				.fin(meter_clks[i]),
				.enable(ctrl.meter_enable),
				.result(results[i])
			);
			assign meter_valid[i] = results[i].valid;
		end
	endgenerate

	led_driver u_leds (
		.hw(hw),
		.rst_n(rst_n),
		.mode(ctrl.led_mode),
		.pattern(ctrl.pattern),
		.meter_valid(meter_valid),
		.leds(leds)
	);

endmodule

/* hdl/led_driver.sv */
`timescale 1ns/1ps

module led_driver (
	input logic hw,
	input logic rst_n,
	input board_monitor_pkg::led_mode_e mode,
	input logic [7:0] pattern,
	input logic [board_monitor_pkg::NUM_METERS-1:0] meter_valid,
	output logic [7:0] leds
);
	import board_monitor_pkg::*;

	logic [HB_SHIFT+7:0] hb_cnt; // Heartbeat counter.
	logic [NUM_METERS-1:0] activity; // One toggle per meter.
	logic [7:0] led_src; // Selected source before the register.

	always_ff @(posedge hw) begin
		if (!rst_n) begin
			hb_cnt <= '0;
			activity <= '0;
		end else begin
			hb_cnt <= hb_cnt + 1'b1; // Free running.
			activity <= activity ^ meter_valid; // Flip on each update.
		end
	end

	always_comb begin
		case (mode)
			LED_HEARTBEAT: led_src = hb_cnt[HB_SHIFT +: 8]; // Slow bits only.
			LED_PATTERN: led_src = pattern;
			LED_ACTIVITY: led_src = 8'(activity); // Upper LEDs stay dark.
			LED_OFF: led_src = '0;
			default: led_src = '0;
		endcase
	end

	// Registered output, one cycle behind the source.
	always_ff @(posedge hw) begin
		if (!rst_n) begin
			leds <= '0;
		end else begin
			leds <= led_src;
		end
	end

endmodule

/* hdl/monitor_regs.sv */
`timescale 1ns/1ps

module monitor_regs (
	input logic hw,
	input logic rst_n,
	input board_monitor_pkg::axil_req_t axil_req,
	output board_monitor_pkg::axil_rsp_t axil_rsp,
	input board_monitor_pkg::freq_result_t results [board_monitor_pkg::NUM_METERS],
	output board_monitor_pkg::monitor_ctrl_t ctrl
);
	import board_monitor_pkg::*;

	axil_state_e state; // Bus engine state.
	logic wr_hs; // Write address and data accepted.
	logic rd_hs; // Read address accepted.
	logic bvalid; // Write response pending.
	logic [1:0] bresp; // Held write response.
	logic rvalid; // Read data pending.
	logic [AXIL_DATA_WIDTH-1:0] rdata; // Held read data.
	logic [1:0] rresp; // Held read response.
	logic [1:0] wr_resp; // Decoded write response.
	logic [AXIL_DATA_WIDTH-1:0] rd_data; // Read mux output.
	logic [1:0] rd_resp; // Decoded read response.
	logic [FREQ_WIDTH-1:0] freq_regs [NUM_METERS]; // Latest meter counts.

	// Reads win over a write arriving in the same cycle.
	assign rd_hs = (state == IDLE) && axil_req.arvalid;
	assign wr_hs = (state == IDLE) && axil_req.awvalid && axil_req.wvalid && !axil_req.arvalid;

	always_comb begin
		axil_rsp = '0;
		axil_rsp.awready = wr_hs; // Address and data ready together.
		axil_rsp.wready = wr_hs;
		axil_rsp.arready = rd_hs;
		axil_rsp.bvalid = bvalid;
		axil_rsp.bresp = bresp;
		axil_rsp.rvalid = rvalid;
		axil_rsp.rdata = rdata;
		axil_rsp.rresp = rresp;
	end

	always_comb begin
		case (reg_addr_e'(axil_req.awaddr))
			REG_ID, REG_CTRL, REG_PATTERN: wr_resp = RESP_OKAY;
			REG_FREQ0, REG_FREQ1, REG_FREQ2, REG_FREQ3: wr_resp = RESP_OKAY; // Read-only, dropped.
			default: wr_resp = RESP_SLVERR;
		endcase
	end

	always_comb begin
		rd_data = '0; // Unmapped reads return zero.
		rd_resp = RESP_OKAY;
		case (reg_addr_e'(axil_req.araddr))
			REG_ID: rd_data = BOARD_ID;
			REG_CTRL: begin
				rd_data[CTRL_EN_BIT] = ctrl.meter_enable;
				rd_data[CTRL_MODE_LSB +: 2] = ctrl.led_mode;
			end
			REG_PATTERN: rd_data[7:0] = ctrl.pattern;
			REG_FREQ0: rd_data = freq_regs[0];
			REG_FREQ1: rd_data = freq_regs[1];
			REG_FREQ2: rd_data = freq_regs[2];
			REG_FREQ3: rd_data = freq_regs[3];
			default: rd_resp = RESP_SLVERR;
		endcase
	end

	// Counts follow the meters and clear while they are stopped.
	always_ff @(posedge hw) begin
		for (int i = 0; i < NUM_METERS; i++) begin
			if (!rst_n || !ctrl.meter_enable) begin
				freq_regs[i] <= '0;
			end else if (results[i].valid) begin
				freq_regs[i] <= results[i].count; // Capture on window end.
			end
		end
	end

	always_ff @(posedge hw) begin
		if (rd_hs) begin
			rdata <= rd_data; // Sampled at address handshake.
			rresp <= rd_resp;
		end
		if (wr_hs) begin
			bresp <= wr_resp;
		end
	end

	always_ff @(posedge hw) begin
		if (!rst_n) begin
			state <= IDLE;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			ctrl.meter_enable <= 1'b1; // Meters run from reset.
			ctrl.led_mode <= LED_HEARTBEAT;
			ctrl.pattern <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (rd_hs) begin
						rvalid <= 1'b1;
						state <= READ_RESP;
					end else if (wr_hs) begin
						bvalid <= 1'b1;
						state <= WRITE_RESP;
					end
				end
				WRITE_RESP: begin
					if (axil_req.bready) begin
						bvalid <= 1'b0; // Response taken.
						state <= IDLE;
					end
				end
				READ_RESP: begin
					if (axil_req.rready) begin
						rvalid <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
			if (wr_hs) begin
				case (reg_addr_e'(axil_req.awaddr))
					REG_CTRL: begin
						if (axil_req.wstrb[0]) ctrl.meter_enable <= axil_req.wdata[CTRL_EN_BIT];
						if (axil_req.wstrb[1]) begin
							ctrl.led_mode <= led_mode_e'(axil_req.wdata[CTRL_MODE_LSB +: 2]);
						end
					end
					REG_PATTERN: begin
						if (axil_req.wstrb[0]) ctrl.pattern <= axil_req.wdata[7:0];
					end
					default: ; // Nothing writable here.
				endcase
			end
		end
	end

endmodule

/* hdl/freq_meter.sv */
`timescale 1ns/1ps

module freq_meter (
	input logic hw,
	input logic rst_n,
	input logic fin,
	input logic enable,
	output board_monitor_pkg::freq_result_t result
);
	import board_monitor_pkg::*;

	logic fin_meta; // First synchronizer stage.
	logic fin_sync; // Second synchronizer stage.
	logic fin_prev; // Delayed copy for edge detect.
	logic rise; // One hw cycle per input rising edge.
	logic [$clog2(GATE_CYCLES)-1:0] gate_cnt; // Position inside the gate window.
	logic gate_end; // Last cycle of the window.
	logic [FREQ_WIDTH-1:0] edge_cnt; // Edges seen so far in this window.

	// Input clock is sampled as data, so it must stay below hw/2.
	always_ff @(posedge hw) begin
		if (!rst_n) begin
			fin_meta <= 1'b0;
			fin_sync <= 1'b0;
			fin_prev <= 1'b0;
		end else begin
			fin_meta <= fin; // May go metastable.
			fin_sync <= fin_meta; // Settled level.
			fin_prev <= fin_sync; // Previous level.
		end
	end

	assign rise = fin_sync & ~fin_prev; // Low to high seen.
	assign gate_end = (gate_cnt == $bits(gate_cnt)'(GATE_CYCLES - 1)); // Window closes.

	always_ff @(posedge hw) begin
		if (!rst_n || !enable) begin
			gate_cnt <= '0; // Next window starts on enable.
			edge_cnt <= '0;
			result.count <= '0; // Disabled meter reads zero.
			result.valid <= 1'b0;
		end else if (gate_end) begin
			gate_cnt <= '0; // Back-to-back windows.
			edge_cnt <= '0; // Restart edge count.
			result.count <= edge_cnt + FREQ_WIDTH'(rise); // Include the last cycle.
			result.valid <= 1'b1; // Publish.
		end else begin
			gate_cnt <= gate_cnt + 1'b1;
			edge_cnt <= edge_cnt + FREQ_WIDTH'(rise);
			result.valid <= 1'b0;
		end
	end

endmodule

/* hdl/board_monitor_pkg.sv */
package board_monitor_pkg;

	localparam int NUM_METERS = 4; // Measured board clocks.
	localparam int GATE_CYCLES = 1024; // Gate window in hw cycles.
	localparam int FREQ_WIDTH = 32; // Width of one frequency result.
	localparam logic [31:0] BOARD_ID = 32'hB0A2_D041; // Fixed board identifier.
	localparam int HB_SHIFT = 4; // Heartbeat bit on LED 0, about 24 on hardware.
	localparam int AXIL_ADDR_WIDTH = 8;
	localparam int AXIL_DATA_WIDTH = 32;

	// REG_CTRL layout: byte 0 holds the meter enable, byte 1 the LED mode.
	localparam int CTRL_EN_BIT = 0; // Meter enable bit.
	localparam int CTRL_MODE_LSB = 8; // LED mode field, two bits.

	localparam logic [1:0] RESP_OKAY = 2'b00; // Normal access.
	localparam logic [1:0] RESP_SLVERR = 2'b10; // Unmapped offset.

	typedef enum logic [1:0] {
		LED_HEARTBEAT = 2'd0, // Free-running counter.
		LED_PATTERN = 2'd1, // Software test pattern.
		LED_ACTIVITY = 2'd2, // Meter update toggles.
		LED_OFF = 2'd3 // All dark.
	} led_mode_e;

	typedef enum logic [7:0] {
		REG_ID = 8'h00,
		REG_CTRL = 8'h04,
		REG_PATTERN = 8'h08,
		REG_FREQ0 = 8'h10,
		REG_FREQ1 = 8'h14,
		REG_FREQ2 = 8'h18,
		REG_FREQ3 = 8'h1C
	} reg_addr_e;

	typedef enum logic [1:0] {
		IDLE,
		WRITE_RESP,
		READ_RESP
	} axil_state_e;

	typedef struct packed {
		logic awvalid;
		logic [AXIL_ADDR_WIDTH-1:0] awaddr;
		logic wvalid;
		logic [AXIL_DATA_WIDTH-1:0] wdata;
		logic [AXIL_DATA_WIDTH/8-1:0] wstrb;
		logic bready;
		logic arvalid;
		logic [AXIL_ADDR_WIDTH-1:0] araddr;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [AXIL_DATA_WIDTH-1:0] rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

	typedef struct packed {
		logic meter_enable; // Runs all meters.
		led_mode_e led_mode; // LED source select.
		logic [7:0] pattern; // Test pattern for LED_PATTERN.
	} monitor_ctrl_t;

	typedef struct packed {
		logic [FREQ_WIDTH-1:0] count; // Edges in the last window.
		logic valid; // One cycle when count updates.
	} freq_result_t;

endpackage
